// ==== hdl/codec_pkg.sv ====
`default_nettype none

package codec_pkg;

  // Host command addresses
  localparam logic [5:0] CMD_TX_GAIN   = 6'h09;
  localparam logic [5:0] CMD_RX_GAIN   = 6'h0a;
  localparam logic [5:0] CMD_REG_WRITE = 6'h3b;

  localparam logic [7:0] REG_WRITE_PREFIX = 8'h06;  // Top byte of a valid generic write

  // Front end registers touched by gain commands
  localparam logic [4:0] REG_TX_GAIN = 5'h0a;
  localparam logic [4:0] REG_RX_GAIN = 5'h09;

  localparam logic [6:0] RX_GAIN_RESET = 7'h40;

  localparam int FRAME_BITS     = 16;
  localparam int SPI_BIT_W      = $clog2(FRAME_BITS);
  localparam int SPI_FIFO_DEPTH = 4;
  localparam int SPI_FIFO_AW    = $clog2(SPI_FIFO_DEPTH);

  // Enable bit and value, indexed by register address
  localparam int INIT_LEN = 20;
  localparam logic [8:0] INIT_TABLE [INIT_LEN] = '{
    9'h000, 9'h000, 9'h000, 9'h000, 9'h000,
    9'h000, 9'h154, 9'h130, 9'h000, 9'h000,
    9'h000, 9'h100, 9'h143, 9'h103, 9'h181,
    9'h000, 9'h180, 9'h100, 9'h100, 9'h000
  };

  typedef struct packed {
    logic [4:0] addr;
    logic [7:0] value;
  } spi_word_t;

  typedef struct packed {
    logic [3:0]  gain;
    logic [27:0] unused;
  } tx_gain_view_t;

  typedef struct packed {
    logic [24:0] unused;
    logic [6:0]  gain;
  } rx_gain_view_t;

  typedef struct packed {
    logic [7:0] prefix;
    logic [2:0] unused_hi;
    logic [4:0] addr;
    logic [7:0] unused_lo;
    logic [7:0] value;
  } reg_write_view_t;

  // Host data word, view picked by cmd_addr
  typedef union packed {
    tx_gain_view_t   tx;
    rx_gain_view_t   rx;
    reg_write_view_t wr;
  } cmd_word_u;

endpackage

`default_nettype wire

// ==== hdl/spi_word_if.sv ====
`default_nettype none

// One register write per four-phase handshake
interface spi_word_if;
  import codec_pkg::*;

  logic      req;
  logic      ack;
  spi_word_t word;
  logic      busy;  // Driven by the receiving side of the link

  modport src (output req, output word, input ack, input busy);
  modport dst (input req, input word, output ack, output busy);

endinterface

`default_nettype wire

// ==== hdl/codec_cmd_seq.sv ====
`default_nettype none

module codec_cmd_seq (
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [5:0]  cmd_addr,
  input  wire  [31:0] cmd_data,
  input  wire         cmd_req,
  output logic        cmd_ack,
  spi_word_if.src     wr
);
  import codec_pkg::*;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_DRAIN,
    ST_CMD,
    ST_PUSH,
    ST_CMD_ACK
  } seq_state_t;

  seq_state_t state;
  logic [4:0] idx;          // Init table address, INIT_LEN once finished
  logic [8:0] init_entry;
  logic       init_load;
  logic [3:0] tx_gain;
  logic [6:0] rx_gain;
  cmd_word_u  cmd_w;
  logic       cmd_take;
  logic       cmd_write;
  spi_word_t  cmd_wword;

  // Front end receive gain code
  function automatic logic [5:0] rx_gain_code(input logic [6:0] gain);
    if (gain[6]) begin
      return gain[5:0];
    end else if (gain[5]) begin
      return ~gain[5:0];
    end
    return {1'b1, gain[4:0]};
  endfunction

  assign init_entry = (idx < 5'(INIT_LEN)) ? INIT_TABLE[idx] : '0;
  assign init_load  = (state == ST_INIT) && init_entry[8];

  assign cmd_w    = cmd_data;
  assign cmd_take = (state == ST_CMD) && cmd_req && !cmd_ack;

  always_comb begin
    cmd_write = 1'b0;
    cmd_wword = '{addr: cmd_w.wr.addr, value: cmd_w.wr.value};
    case (cmd_addr)
      CMD_TX_GAIN: begin
        cmd_write = (cmd_w.tx.gain != tx_gain);  // Only on change
        cmd_wword = '{addr: REG_TX_GAIN, value: {4'b0100, cmd_w.tx.gain}};
      end
      CMD_RX_GAIN: begin
        cmd_write = (cmd_w.rx.gain != rx_gain);
        cmd_wword = '{addr: REG_RX_GAIN, value: {2'b01, rx_gain_code(cmd_w.rx.gain)}};
      end
      CMD_REG_WRITE: cmd_write = (cmd_w.wr.prefix == REG_WRITE_PREFIX);
      default: cmd_write = 1'b0;  // Unknown address, ack only
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_INIT;
      idx     <= '0;
      tx_gain <= '0;
      rx_gain <= RX_GAIN_RESET;
      wr.req  <= 1'b0;
      cmd_ack <= 1'b0;
    end else begin
      case (state)
        ST_INIT: begin
          if (idx == 5'(INIT_LEN)) begin
            state <= ST_DRAIN;
          end else if (init_entry[8]) begin
            state <= ST_PUSH;
          end else begin
            idx <= idx + 1'b1;  // Skip disabled entry
          end
        end
        // Wait for the queued init frames to leave
        ST_DRAIN: if (!wr.busy && !wr.ack) state <= ST_CMD;
        ST_CMD: begin
          if (cmd_take) begin
            if (cmd_addr == CMD_TX_GAIN) tx_gain <= cmd_w.tx.gain;
            if (cmd_addr == CMD_RX_GAIN) rx_gain <= cmd_w.rx.gain;
            if (cmd_write) begin
              state <= ST_PUSH;
            end else begin
              cmd_ack <= 1'b1;
              state   <= ST_CMD_ACK;
            end
          end
        end
        ST_PUSH: begin
          if (!wr.req && !wr.ack) begin
            wr.req <= 1'b1;
          end else if (wr.req && wr.ack) begin
            wr.req <= 1'b0;
            if (idx != 5'(INIT_LEN)) begin
              idx   <= idx + 1'b1;
              state <= ST_INIT;
            end else begin
              cmd_ack <= 1'b1;
              state   <= ST_CMD_ACK;
            end
          end
        end
        ST_CMD_ACK: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= ST_CMD;
          end
        end
        default: state <= ST_INIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (init_load) begin
      wr.word <= '{addr: idx, value: init_entry[7:0]};
    end else if (cmd_take) begin
      wr.word <= cmd_wword;
    end
  end

  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    wr.req && !wr.ack |=> wr.req)
    else $error("write request dropped before ack");

endmodule

`default_nettype wire

// ==== hdl/spi_word_fifo.sv ====
`default_nettype none

module spi_word_fifo (
  input wire      clk,
  input wire      rst_n,
  spi_word_if.dst in_w,
  spi_word_if.src out_w
);
  import codec_pkg::*;

  spi_word_t              mem [SPI_FIFO_DEPTH];
  logic [SPI_FIFO_AW-1:0] wr_ptr;
  logic [SPI_FIFO_AW-1:0] rd_ptr;
  logic [SPI_FIFO_AW:0]   count;
  logic                   full;
  logic                   empty;
  logic                   push;
  logic                   pop;

  assign full  = (count == (SPI_FIFO_AW + 1)'(SPI_FIFO_DEPTH));
  assign empty = (count == '0);
  assign push  = in_w.req && !in_w.ack && !full;  // Full leaves req hanging
  assign pop   = out_w.req && out_w.ack;

  // Queue or serial master still working
  assign in_w.busy  = !empty || out_w.busy;
  assign out_w.word = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_w.word;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_w.ack  <= 1'b0;
      out_w.req <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      if (push) begin
        in_w.ack <= 1'b1;
      end else if (!in_w.req) begin
        in_w.ack <= 1'b0;
      end

      // Head word offered until the master takes it
      if (pop) begin
        out_w.req <= 1'b0;
      end else if (!out_w.req && !out_w.ack && !empty) begin
        out_w.req <= 1'b1;
      end
    end
  end

  // Count never passes the depth and matches the pointer distance
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (SPI_FIFO_AW + 1)'(SPI_FIFO_DEPTH) &&
    SPI_FIFO_AW'(wr_ptr - rd_ptr) == count[SPI_FIFO_AW-1:0])
    else $error("write accepted while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    out_w.req |-> !empty)
    else $error("read offered while empty");

endmodule

`default_nettype wire

// ==== hdl/codec_spi_master.sv ====
`default_nettype none

module codec_spi_master (
  input  wire      clk,
  input  wire      rst_n,
  spi_word_if.dst  rd,
  output logic     spi_sen_n,
  output logic     spi_sclk,
  output logic     spi_sdio
);
  import codec_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_START,
    M_SHIFT,
    M_END
  } spi_state_t;

  spi_state_t            state;
  logic [FRAME_BITS-1:0] shreg;
  logic [SPI_BIT_W-1:0]  bit_cnt;
  logic [1:0]            phase;    // Two cycles sclk low, two high
  logic                  accept;

  assign accept   = (state == M_IDLE) && rd.req && !rd.ack;
  assign spi_sdio = shreg[FRAME_BITS-1];  // MSB first
  assign rd.busy  = (state != M_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= M_IDLE;
      shreg     <= '0;
      bit_cnt   <= '0;
      phase     <= '0;
      spi_sen_n <= 1'b1;
      spi_sclk  <= 1'b0;
      rd.ack    <= 1'b0;
    end else begin
      if (accept) begin
        rd.ack <= 1'b1;
      end else if (!rd.req) begin
        rd.ack <= 1'b0;
      end

      case (state)
        M_IDLE: begin
          if (accept) begin
            shreg <= {3'b000, rd.word};  // Three zero bits, then addr and value
            state <= M_START;
          end
        end
        M_START: begin
          spi_sen_n <= 1'b0;
          phase     <= '0;
          bit_cnt   <= SPI_BIT_W'(FRAME_BITS - 1);
          state     <= M_SHIFT;
        end
        M_SHIFT: begin
          phase <= phase + 1'b1;
          if (phase == 2'd1) spi_sclk <= 1'b1;
          if (phase == 2'd3) begin
            spi_sclk <= 1'b0;
            if (bit_cnt == '0) begin
              state <= M_END;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
              shreg   <= {shreg[FRAME_BITS-2:0], 1'b0};  // Next bit on falling edge
            end
          end
        end
        M_END: begin
          // Hold enable 2 cycles past last falling edge
          phase <= phase + 1'b1;
          if (phase == 2'd1) begin
            spi_sen_n <= 1'b1;
            state     <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  a_sen_during_sclk: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(spi_sclk) |-> !spi_sen_n && $past(!spi_sen_n))
    else $error("sclk toggled outside a frame");

endmodule

`default_nettype wire

// ==== hdl/codec_sample_port.sv ====
`default_nettype none

module codec_sample_port (
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [11:0] tx_data,
  input  wire         tx_en,
  input  wire  [5:0]  codec_rx,
  input  wire         codec_rxsync,
  input  wire         rx_clr_status,
  output logic        tx_strobe,
  output logic [5:0]  codec_tx,
  output logic        codec_txsync,
  output logic        codec_txquiet_n,
  output logic [11:0] rx_data,
  output logic        rx_valid,
  output logic        rx_clip,
  output logic        rx_good_lvl
);

  logic       tx_phase;   // High in the low-nibble cycle
  logic [5:0] tx_low;
  logic [5:0] rx_d1;
  logic [5:0] rx_d2;
  logic       sync_d1;
  logic       sync_d2;
  logic       clip_hit;
  logic       good_hit;

  assign tx_strobe = tx_en && !tx_phase;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_phase        <= 1'b0;
      codec_tx        <= '0;
      codec_txsync    <= 1'b0;
      codec_txquiet_n <= 1'b1;
    end else begin
      tx_phase        <= tx_strobe;
      codec_txquiet_n <= tx_en;
      if (tx_strobe) begin
        codec_tx     <= tx_data[11:6];
        codec_txsync <= 1'b1;
      end else if (tx_en) begin
        codec_tx     <= tx_low;
        codec_txsync <= 1'b0;
      end else begin
        codec_tx     <= '0;  // Idle bus
        codec_txsync <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_strobe) tx_low <= tx_data[5:0];
  end

  // Receive pipeline, sync marks the high nibble
  always_ff @(posedge clk) begin
    rx_d1 <= codec_rx;
    rx_d2 <= rx_d1;
    if (sync_d2) rx_data <= {rx_d2, rx_d1};
  end

  assign clip_hit = (rx_data == 12'h7ff) || (rx_data == 12'h800);
  assign good_hit = (rx_data[11:9] == 3'b011) || (rx_data[11:9] == 3'b100);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_d1     <= 1'b0;
      sync_d2     <= 1'b0;
      rx_valid    <= 1'b0;
      rx_clip     <= 1'b0;
      rx_good_lvl <= 1'b0;
    end else begin
      sync_d1  <= codec_rxsync;
      sync_d2  <= sync_d1;
      rx_valid <= sync_d2;
      // Set beats clear
      if (rx_clr_status) rx_clip <= 1'b0;
      if (rx_valid && clip_hit) rx_clip <= 1'b1;
      if (rx_clr_status) rx_good_lvl <= 1'b0;
      if (rx_valid && good_hit) rx_good_lvl <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/codec_ctrl_top.sv ====
`default_nettype none

module codec_ctrl_top (
  input  wire        clk,
  input  wire        rst_n,
  input  wire [5:0]  cmd_addr,
  input  wire [31:0] cmd_data,
  input  wire        cmd_req,
  output wire        cmd_ack,
  input  wire [11:0] tx_data,
  input  wire        tx_en,
  output wire        tx_strobe,
  output wire [5:0]  codec_tx,
  output wire        codec_txsync,
  output wire        codec_txquiet_n,
  input  wire [5:0]  codec_rx,
  input  wire        codec_rxsync,
  output wire [11:0] rx_data,
  output wire        rx_valid,
  output wire        rx_clip,
  output wire        rx_good_lvl,
  input  wire        rx_clr_status,
  output wire        spi_sen_n,
  output wire        spi_sclk,
  output wire        spi_sdio
);

  spi_word_if seq_to_fifo ();
  spi_word_if fifo_to_spi ();

  codec_cmd_seq u_cmd_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .wr       (seq_to_fifo.src)
  );

  // Lets commands queue while a frame shifts out
  spi_word_fifo u_spi_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .in_w  (seq_to_fifo.dst),
    .out_w (fifo_to_spi.src)
  );

  codec_spi_master u_spi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd        (fifo_to_spi.dst),
    .spi_sen_n (spi_sen_n),
    .spi_sclk  (spi_sclk),
    .spi_sdio  (spi_sdio)
  );

  codec_sample_port u_sample_port (
    .clk             (clk),
    .rst_n           (rst_n),
    .tx_data         (tx_data),
    .tx_en           (tx_en),
    .codec_rx        (codec_rx),
    .codec_rxsync    (codec_rxsync),
    .rx_clr_status   (rx_clr_status),
    .tx_strobe       (tx_strobe),
    .codec_tx        (codec_tx),
    .codec_txsync    (codec_txsync),
    .codec_txquiet_n (codec_txquiet_n),
    .rx_data         (rx_data),
    .rx_valid        (rx_valid),
    .rx_clip         (rx_clip),
    .rx_good_lvl     (rx_good_lvl)
  );

endmodule

`default_nettype wire

// ==== verif/tb_codec_ctrl.sv ====
`default_nettype none

module tb_codec_ctrl;
  timeunit 1ns;
  timeprecision 1ps;
  import codec_pkg::*;

  localparam int TIMEOUT_CYCLES = 8000;  // About 25 frames plus sample tests

  logic        clk;
  logic        rst_n;
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_req;
  logic        cmd_ack;
  logic [11:0] tx_data;
  logic        tx_en;
  logic        tx_strobe;
  logic [5:0]  codec_tx;
  logic        codec_txsync;
  logic        codec_txquiet_n;
  logic [5:0]  codec_rx;
  logic        codec_rxsync;
  logic [11:0] rx_data;
  logic        rx_valid;
  logic        rx_clip;
  logic        rx_good_lvl;
  logic        rx_clr_status;
  logic        spi_sen_n;
  logic        spi_sclk;
  logic        spi_sdio;

  integer      seed;
  int          checks;
  int          errors;
  int          cycles;
  logic [15:0] frames [$];  // Frames seen on the serial port
  logic [15:0] frame_bits;
  int          bit_num;
  logic        sclk_q;
  logic        sen_q;

  // Enabled init entries in address order
  logic [4:0] init_addr [9] = '{5'h06, 5'h07, 5'h0b, 5'h0c, 5'h0d, 5'h0e, 5'h10, 5'h11, 5'h12};
  logic [7:0] init_val  [9] = '{8'h54, 8'h30, 8'h00, 8'h43, 8'h03, 8'h81, 8'h80, 8'h00, 8'h00};

  codec_ctrl_top u_codec_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Serial frame monitor, bit taken on each sclk rise
  always @(posedge clk) begin
    sclk_q <= spi_sclk;
    sen_q  <= spi_sen_n;
    if (!rst_n) begin
      bit_num = 0;
    end else begin
      if (!spi_sen_n && spi_sclk && !sclk_q) begin
        frame_bits = {frame_bits[14:0], spi_sdio};
        bit_num    = bit_num + 1;
      end
      if (spi_sen_n && !sen_q) begin
        if (bit_num != FRAME_BITS) begin
          $display("Serial frame ended after %0d bits instead of %0d", bit_num, FRAME_BITS);
          errors++;
        end
        frames.push_back(frame_bits);
        bit_num = 0;
      end
    end
  end

  task automatic check_equal(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic expect_frame(input logic [4:0] addr, input logic [7:0] value);
    logic [15:0] f;
    while (frames.size() == 0) @(posedge clk);
    f = frames.pop_front();
    check_equal("frame lead bits", 32'(f[15:13]), 32'd0);
    check_equal("frame address", 32'(f[12:8]), 32'(addr));
    check_equal("frame value", 32'(f[7:0]), 32'(value));
  endtask

  // Full four-phase cycle on the host port
  task automatic send_command(input logic [5:0] addr, input logic [31:0] data);
    @(posedge clk);
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_req  <= 1'b1;
    do @(posedge clk); while (!cmd_ack);
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
  endtask

  task automatic reset_state;
    check_equal("cmd_ack in reset", 32'(cmd_ack), 32'd0);
    check_equal("spi_sen_n in reset", 32'(spi_sen_n), 32'd1);
    check_equal("spi_sclk in reset", 32'(spi_sclk), 32'd0);
    check_equal("tx_strobe in reset", 32'(tx_strobe), 32'd0);
    check_equal("codec_txsync in reset", 32'(codec_txsync), 32'd0);
    check_equal("codec_txquiet_n in reset", 32'(codec_txquiet_n), 32'd1);
    check_equal("rx_valid in reset", 32'(rx_valid), 32'd0);
    check_equal("rx_clip in reset", 32'(rx_clip), 32'd0);
    check_equal("rx_good_lvl in reset", 32'(rx_good_lvl), 32'd0);
  endtask

  task automatic init_table_frames;
    for (int i = 0; i < 9; i++) expect_frame(init_addr[i], init_val[i]);
  endtask

  task automatic tx_gain_commands;
    send_command(CMD_TX_GAIN, 32'h5000_0000);
    expect_frame(5'h0a, 8'h45);
    send_command(CMD_TX_GAIN, 32'h5000_0000);  // Same gain, ack only
  endtask

  task automatic rx_gain_mapping;
    send_command(CMD_RX_GAIN, 32'h0000_0045);
    expect_frame(5'h09, 8'h45);  // Bit 6 set, low six bits
    send_command(CMD_RX_GAIN, 32'h0000_0025);
    expect_frame(5'h09, 8'h5a);  // Bit 5 set, inverted 6'h25
    send_command(CMD_RX_GAIN, 32'h0000_0005);
    expect_frame(5'h09, 8'h65);  // One then low five bits
  endtask

  task automatic generic_writes;
    logic [7:0] vals [4];
    send_command(CMD_REG_WRITE, 32'h0613_00a5);
    expect_frame(5'h13, 8'ha5);
    send_command(CMD_REG_WRITE, 32'h0713_00a5);  // Wrong prefix
    send_command(6'h20, 32'h0613_00a5);          // Unknown command address
    for (int i = 0; i < 4; i++) begin
      vals[i] = 8'($random(seed));
      send_command(CMD_REG_WRITE, {8'h06, 3'b000, 5'(i + 1), 8'h00, vals[i]});
    end
    for (int i = 0; i < 4; i++) expect_frame(5'(i + 1), vals[i]);
  endtask

  task automatic send_rx_pair(input logic [11:0] word);
    @(posedge clk);
    codec_rx     <= word[11:6];
    codec_rxsync <= 1'b1;
    @(posedge clk);
    codec_rx     <= word[5:0];
    codec_rxsync <= 1'b0;
    do @(posedge clk); while (!rx_valid);
    check_equal("rx_data", 32'(rx_data), 32'(word));
  endtask

  task automatic sample_paths;
    logic [11:0] word;
    @(posedge clk);
    tx_data <= 12'($random(seed));
    tx_en   <= 1'b1;
    do @(posedge clk); while (!tx_strobe);
    for (int i = 0; i < 8; i++) begin
      word = tx_data;  // Sampled by the DUT at this edge
      tx_data <= 12'($random(seed));
      @(posedge clk);
      check_equal("codec_tx high nibble", 32'(codec_tx), 32'(word[11:6]));
      check_equal("codec_txsync high", 32'(codec_txsync), 32'd1);
      check_equal("codec_txquiet_n", 32'(codec_txquiet_n), 32'd1);
      @(posedge clk);
      check_equal("codec_tx low nibble", 32'(codec_tx), 32'(word[5:0]));
      check_equal("codec_txsync low", 32'(codec_txsync), 32'd0);
      check_equal("tx_strobe", 32'(tx_strobe), 32'd1);
    end
    tx_en <= 1'b0;
    repeat (2) @(posedge clk);
    check_equal("codec_tx idle", 32'(codec_tx), 32'd0);
    check_equal("codec_txquiet_n idle", 32'(codec_txquiet_n), 32'd0);
    for (int i = 0; i < 8; i++) send_rx_pair(12'($random(seed)));
  endtask

  task automatic clear_flags;
    @(posedge clk);
    rx_clr_status <= 1'b1;
    @(posedge clk);
    rx_clr_status <= 1'b0;
    @(posedge clk);
    check_equal("rx_clip after clear", 32'(rx_clip), 32'd0);
    check_equal("rx_good_lvl after clear", 32'(rx_good_lvl), 32'd0);
  endtask

  task automatic status_flags;
    clear_flags();
    send_rx_pair(12'h7ff);  // Full scale, top bits 011 too
    @(posedge clk);
    check_equal("rx_clip on 0x7ff", 32'(rx_clip), 32'd1);
    check_equal("rx_good_lvl on 0x7ff", 32'(rx_good_lvl), 32'd1);
    clear_flags();
    send_rx_pair(12'h6a5);
    @(posedge clk);
    check_equal("rx_clip on 0x6a5", 32'(rx_clip), 32'd0);
    check_equal("rx_good_lvl on 0x6a5", 32'(rx_good_lvl), 32'd1);
    clear_flags();
    send_rx_pair(12'h100);
    @(posedge clk);
    check_equal("rx_clip on 0x100", 32'(rx_clip), 32'd0);
    check_equal("rx_good_lvl on 0x100", 32'(rx_good_lvl), 32'd0);
  endtask

  initial begin
    seed          = 89;
    checks        = 0;
    errors        = 0;
    cycles        = 0;
    rst_n         = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_req       = 1'b0;
    tx_data       = '0;
    tx_en         = 1'b0;
    codec_rx      = '0;
    codec_rxsync  = 1'b0;
    rx_clr_status = 1'b0;
    repeat (2) @(posedge clk);
    reset_state();
    rst_n <= 1'b1;

    init_table_frames();
    tx_gain_commands();
    rx_gain_mapping();
    generic_writes();
    sample_paths();
    status_flags();
    check_equal("extra frames", 32'(frames.size()), 32'd0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/codec_pkg.sv
hdl/spi_word_if.sv
hdl/codec_cmd_seq.sv
hdl/spi_word_fifo.sv
hdl/codec_spi_master.sv
hdl/codec_sample_port.sv
hdl/codec_ctrl_top.sv
verif/tb_codec_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the codec control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_codec_ctrl \
  -f sim.f \
  -o sim_codec_ctrl

./obj_dir/sim_codec_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
echo "Simulation did not pass"
exit 1
